/* filelist.f */
rtl/alu_pkg.sv
rtl/alu_add.sv
rtl/alu_shift.sv
rtl/alu.sv
rtl/issue_queue.sv
rtl/exe_stage.sv
rtl/alu_top.sv
testbench/tb_clock.sv
testbench/alu_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f filelist.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The log decides the verdict
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import alu_pkg::*;
();

localparam int NUM_REQS       = 2000;
localparam int RESET_CYCLES   = 16;
localparam int TIMEOUT_CYCLES = NUM_REQS * 8 + RESET_CYCLES;
localparam int DRAIN_CYCLES   = 20;

logic      clk;
logic      rst;
logic      req_valid;
alu_req_t  req;
logic      req_ready;
logic      wb_valid;
alu_resp_t wb;
logic      wb_ready;
int        resp_count;
int        err_count;
int        cycle_count = 0;

tb_clock clock_gen (
    .clk_o (clk)
);

alu_top uut (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .wb_valid_o  (wb_valid),
    .wb_o        (wb),
    .wb_ready_i  (wb_ready)
);

alu_checker scoreboard (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_i  (req_ready),
    .wb_valid_i   (wb_valid),
    .wb_i         (wb),
    .wb_ready_i   (wb_ready),
    .resp_count_o (resp_count),
    .err_count_o  (err_count)
);

// --------------------------------------------------
// Random stimulus
// --------------------------------------------------

// Corners mixed in with plain random words
function automatic bus64_t random_operand();
    bus64_t     rnd;
    logic [5:0] amt;
    rnd = {$urandom(), $urandom()};
    case ($urandom_range(0, 3))
        0:       amt = 6'd0;
        1:       amt = 6'd31;
        2:       amt = 6'd32;
        default: amt = 6'd63;
    endcase
    case ($urandom_range(0, 7))
        0:       rnd = '0;
        1:       rnd = '1;
        2:       rnd = 64'h8000_0000_0000_0000;
        3:       rnd[31] = 1'b1;
        4:       rnd = {rnd[63:6], amt};
        default: rnd = rnd;
    endcase
    return rnd;
endfunction

function automatic alu_req_t random_request();
    alu_req_t   r;
    logic [4:0] op_bits;
    op_bits      = 5'($urandom_range(0, 23));
    r.op         = alu_op_t'(op_bits);
    r.rd         = 5'($urandom_range(0, 31));
    r.regfile_we = 1'($urandom_range(0, 1));
    r.data_rs1   = random_operand();
    r.data_rs2   = random_operand();
    return r;
endfunction

initial begin : stimulus
    int gap;
    void'($urandom(32'hfbea_92b4));
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    wb_ready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NUM_REQS; i++) begin
        gap       = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 4)) : 0;
        req_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        req       = random_request();
        req_valid = 1'b1;
        // Hold the request until the queue has room
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    end
    req_valid = 1'b0;

    while (resp_count < NUM_REQS) begin
        @(posedge clk);
        #1;
    end
    // Extra cycles expose a repeated response
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("Responses checked: %0d of %0d, errors: %0d", resp_count, NUM_REQS, err_count);
    if (err_count == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

// Writeback back-pressure with occasional long stalls
initial begin : backpressure
    int stall_left;
    stall_left = 0;
    wait (rst == 1'b0);
    forever begin
        @(posedge clk);
        #1;
        if (stall_left > 0) begin
            wb_ready   = 1'b0;
            stall_left = stall_left - 1;
        end else if ($urandom_range(0, 39) == 0) begin
            wb_ready   = 1'b0;
            stall_left = int'($urandom_range(8, 20));
        end else begin
            wb_ready = ($urandom_range(0, 3) != 0);
        end
    end
end

// --------------------------------------------------
// Timeout
// --------------------------------------------------

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
end

initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles: responses are missing, %0d of %0d arrived, errors: %0d",
             cycle_count, resp_count, NUM_REQS, err_count);
    $display("Test FAILED");
    $finish;
end

endmodule

/* testbench/alu_checker.sv */
`timescale 1ns/1ps

module alu_checker
    import alu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  alu_req_t  req_i,
    input  logic      req_ready_i,
    input  logic      wb_valid_i,
    input  alu_resp_t wb_i,
    input  logic      wb_ready_i,
    output int        resp_count_o,
    output int        err_count_o
);

// Requests accepted at the issue port, oldest first
alu_req_t  pending [$];
alu_resp_t wb_q;
logic      stall_q;
logic      in_reset_q;

function automatic bus64_t sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// --------------------------------------------------
// Reference model
// --------------------------------------------------

function automatic bus64_t model_result(input alu_req_t r);
    bus64_t a;
    bus64_t b;
    bus64_t a_uw;
    bus64_t res;
    a    = r.data_rs1;
    b    = r.data_rs2;
    a_uw = {32'b0, a[31:0]};
    case (r.op)
        ADD:      res = a + b;
        SUB:      res = a - b;
        ADDW:     res = sext_word(a[31:0] + b[31:0]);
        SUBW:     res = sext_word(a[31:0] - b[31:0]);
        ADDUW:    res = a_uw + b;
        SH1ADD:   res = (a << 1) + b;
        SH2ADD:   res = (a << 2) + b;
        SH3ADD:   res = (a << 3) + b;
        SH1ADDUW: res = (a_uw << 1) + b;
        SH2ADDUW: res = (a_uw << 2) + b;
        SH3ADDUW: res = (a_uw << 3) + b;
        SLL:      res = a << b[5:0];
        SRL:      res = a >> b[5:0];
        SRA:      res = $signed(a) >>> b[5:0];
        SLLW:     res = sext_word(a[31:0] << b[4:0]);
        SRLW:     res = sext_word(a[31:0] >> b[4:0]);
        SRAW:     res = sext_word($signed(a[31:0]) >>> b[4:0]);
        SLLIUW:   res = a_uw << b[5:0];
        SLT:      res = {63'b0, $signed(a) < $signed(b)};
        SLTU:     res = {63'b0, a < b};
        AND_INST: res = a & b;
        OR_INST:  res = a | b;
        XOR_INST: res = a ^ b;
        ZEXTW:    res = a_uw;
        default:  res = '0;
    endcase
    return res;
endfunction

task automatic value_error(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    $display("ERROR: %s got %0h expected %0h at %0t", name, got, exp, $time);
    err_count_o++;
endtask

task automatic fault(input string msg);
    $display("Check failed at %0t: %s", $time, msg);
    err_count_o++;
endtask

// --------------------------------------------------
// Scoreboard
// --------------------------------------------------

always @(posedge clk_i) begin
    alu_req_t req;
    bus64_t   exp_result;
    logic     exp_ready;
    if (rst_i) begin
        pending.delete();
        stall_q      = 1'b0;
        in_reset_q   = 1'b1;
        resp_count_o = 0;
        err_count_o  = 0;
    end else begin
        if (in_reset_q && (wb_valid_i || !req_ready_i)) begin
            fault("wb_valid_o high or req_ready_o low right after reset");
        end
        in_reset_q = 1'b0;

        // Held response must not move while writeback stalls
        if (stall_q && !wb_valid_i) begin
            fault("wb_valid_o dropped while wb_ready_i was low");
        end else if (stall_q && wb_i != wb_q) begin
            value_error("wb_o", 128'(wb_i), 128'(wb_q));
        end

        // Full only with four queued and one held in the stage
        exp_ready = (pending.size() != ALU_QUEUE_DEPTH + 1);
        if (req_ready_i != exp_ready) begin
            value_error("req_ready_o", 128'(req_ready_i), 128'(exp_ready));
        end

        if (wb_valid_i && wb_ready_i) begin
            if (pending.size() == 0) begin
                fault("writeback response with no request in flight");
            end else begin
                req        = pending.pop_front();
                exp_result = model_result(req);
                if (wb_i.rd != req.rd) begin
                    value_error("wb_o.rd", 128'(wb_i.rd), 128'(req.rd));
                end
                if (wb_i.regfile_we != req.regfile_we) begin
                    value_error("wb_o.regfile_we", 128'(wb_i.regfile_we),
                                128'(req.regfile_we));
                end
                if (wb_i.result != exp_result) begin
                    value_error($sformatf("wb_o.result (%s)", req.op.name()),
                                128'(wb_i.result), 128'(exp_result));
                end
            end
            resp_count_o++;
        end

        if (req_valid_i && req_ready_i) begin
            pending.push_back(req_i);
        end
        stall_q = wb_valid_i && !wb_ready_i;
        wb_q    = wb_i;
    end
end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

localparam time HALF_PERIOD = 4ns;

initial begin
    clk_o = 1'b0;
    forever begin
        #(HALF_PERIOD) clk_o = ~clk_o;
    end
end

endmodule

/* rtl/alu_top.sv */
`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  alu_req_t  req_i,
    output logic      req_ready_o,
    output logic      wb_valid_o,
    output alu_resp_t wb_o,
    input  logic      wb_ready_i
);

// Queue head toward the execution stage
logic     q_valid;
alu_req_t q_req;
logic     q_ready;

issue_queue issue_queue_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (req_valid_i),
    .push_req_i   (req_i),
    .push_ready_o (req_ready_o),
    .pop_valid_o  (q_valid),
    .pop_req_o    (q_req),
    .pop_ready_i  (q_ready)
);

exe_stage exe_stage_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (q_valid),
    .req_i       (q_req),
    .req_ready_o (q_ready),
    .wb_valid_o  (wb_valid_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
);

endmodule

/* rtl/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage
    import alu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  alu_req_t  req_i,
    output logic      req_ready_o,
    output logic      wb_valid_o,
    output alu_resp_t wb_o,
    input  logic      wb_ready_i
);

bus64_t alu_result;
logic   accept;

// Free slot, or the held result leaves this cycle
assign req_ready_o = !wb_valid_o || wb_ready_i;
assign accept      = req_valid_i && req_ready_o;

alu alu_inst (
    .req_i    (req_i),
    .result_o (alu_result)
);

// --------------------------------------------------
// Response register
// --------------------------------------------------

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wb_valid_o <= 1'b0;
    end else if (accept) begin
        wb_valid_o <= 1'b1;
    end else if (wb_ready_i) begin
        wb_valid_o <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (accept) begin
        wb_o.rd         <= req_i.rd;
        wb_o.regfile_we <= req_i.regfile_we;
        wb_o.result     <= alu_result;
    end
end

// Stalled response holds until writeback takes it
assert property (@(posedge clk_i) disable iff (rst_i)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o));

endmodule

/* rtl/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue
    import alu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_valid_i,
    input  alu_req_t push_req_i,
    output logic     push_ready_o,
    output logic     pop_valid_o,
    output alu_req_t pop_req_o,
    input  logic     pop_ready_i
);

alu_req_t                   mem [ALU_QUEUE_DEPTH];
logic [ALU_QUEUE_PTR_W-1:0] wr_ptr;
logic [ALU_QUEUE_PTR_W-1:0] rd_ptr;
logic [ALU_QUEUE_PTR_W:0]   count;
logic                       push;
logic                       pop;

assign push_ready_o = (count != (ALU_QUEUE_PTR_W+1)'(ALU_QUEUE_DEPTH));
assign pop_valid_o  = (count != '0);
assign pop_req_o    = mem[rd_ptr];

assign push = push_valid_i && push_ready_o;
assign pop  = pop_valid_o && pop_ready_i;

// --------------------------------------------------
// Pointers and occupancy
// --------------------------------------------------

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        // Depth is a power of two, pointers wrap on their own
        if (push) wr_ptr <= wr_ptr + 1'b1;
        if (pop)  rd_ptr <= rd_ptr + 1'b1;
        if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end
end

// Entry storage
always_ff @(posedge clk_i) begin
    if (push) begin
        mem[wr_ptr] <= push_req_i;
    end
end

assert property (@(posedge clk_i) disable iff (rst_i)
    count <= (ALU_QUEUE_PTR_W+1)'(ALU_QUEUE_DEPTH));

// Equal pointers mean empty unless the count says full
assert property (@(posedge clk_i) disable iff (rst_i)
    pop |-> (rd_ptr != wr_ptr) || (count == (ALU_QUEUE_PTR_W+1)'(ALU_QUEUE_DEPTH)));

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
    import alu_pkg::*;
(
    input  alu_req_t req_i,
    output bus64_t   result_o
);

bus64_t data_rs1;
bus64_t data_rs2;
bus64_t data_rs1_ext;
bus64_t data_rs1_pre;
bus64_t add_result;
bus64_t shift_result;
bus64_t cmp_result;
bus64_t logic_result;
bus64_t unit_result;

assign data_rs1 = req_i.data_rs1;
assign data_rs2 = req_i.data_rs2;

// --------------------------------------------------
// Operand preparation
// --------------------------------------------------

// Zero or sign extension of the low word
always_comb begin
    case (req_i.op)
        ADDUW, SH1ADDUW, SH2ADDUW, SH3ADDUW, ZEXTW, SLLIUW, SLLW, SRLW: begin
            data_rs1_ext = {32'b0, data_rs1[31:0]};
        end
        SRAW: begin
            data_rs1_ext = {{32{data_rs1[31]}}, data_rs1[31:0]};
        end
        default: begin
            data_rs1_ext = data_rs1;
        end
    endcase
end

// Pre-shift for the shift-and-add forms
always_comb begin
    case (req_i.op)
        SH1ADD, SH1ADDUW: data_rs1_pre = data_rs1_ext << 1;
        SH2ADD, SH2ADDUW: data_rs1_pre = data_rs1_ext << 2;
        SH3ADD, SH3ADDUW: data_rs1_pre = data_rs1_ext << 3;
        default:          data_rs1_pre = data_rs1_ext;
    endcase
end

// --------------------------------------------------
// Units
// --------------------------------------------------

alu_add alu_add_inst (
    .data_rs1_i (data_rs1_pre),
    .data_rs2_i (data_rs2),
    .op_i       (req_i.op),
    .result_o   (add_result)
);

alu_shift alu_shift_inst (
    .data_rs1_i (data_rs1_ext),
    .data_rs2_i (data_rs2),
    .op_i       (req_i.op),
    .result_o   (shift_result)
);

// Set-less-than, signed or unsigned order
always_comb begin
    if (req_i.op == SLT) begin
        cmp_result = {63'b0, $signed(data_rs1) < $signed(data_rs2)};
    end else begin
        cmp_result = {63'b0, data_rs1 < data_rs2};
    end
end

always_comb begin
    case (req_i.op)
        AND_INST: logic_result = data_rs1 & data_rs2;
        OR_INST:  logic_result = data_rs1 | data_rs2;
        default:  logic_result = data_rs1 ^ data_rs2;
    endcase
end

// --------------------------------------------------
// Result select
// --------------------------------------------------

always_comb begin
    case (req_i.op)
        ADD, SUB, ADDW, SUBW, ADDUW,
        SH1ADD, SH2ADD, SH3ADD, SH1ADDUW, SH2ADDUW, SH3ADDUW: begin
            unit_result = add_result;
        end
        SLL, SRL, SRA, SLLW, SRLW, SRAW, SLLIUW: begin
            unit_result = shift_result;
        end
        SLT, SLTU: begin
            unit_result = cmp_result;
        end
        default: begin
            unit_result = logic_result;
        end
    endcase
end

// Word results take bit 31 as sign
always_comb begin
    case (req_i.op)
        ADDW, SUBW, SLLW, SRLW, SRAW: begin
            result_o = {{32{unit_result[31]}}, unit_result[31:0]};
        end
        ZEXTW: begin
            result_o = data_rs1_ext;
        end
        default: begin
            result_o = unit_result;
        end
    endcase
end

endmodule

/* rtl/alu_shift.sv */
`timescale 1ns/1ps

module alu_shift
    import alu_pkg::*;
(
    input  bus64_t  data_rs1_i,
    input  bus64_t  data_rs2_i,
    input  alu_op_t op_i,
    output bus64_t  result_o
);

logic [5:0] shamt;

// Word forms only look at five bits of the amount
always_comb begin
    case (op_i)
        SLLW, SRLW, SRAW: shamt = {1'b0, data_rs2_i[4:0]};
        default:          shamt = data_rs2_i[5:0];
    endcase
end

always_comb begin
    case (op_i)
        SLL, SLLW, SLLIUW: begin
            result_o = data_rs1_i << shamt;
        end
        SRL, SRLW: begin
            result_o = data_rs1_i >> shamt;
        end
        SRA, SRAW: begin
            // SRAW operand arrives sign-extended from bit 31
            result_o = bus64_t'($signed(data_rs1_i) >>> shamt);
        end
        default: begin
            result_o = '0;
        end
    endcase
end

endmodule

/* rtl/alu_add.sv */
`timescale 1ns/1ps

module alu_add
    import alu_pkg::*;
(
    input  bus64_t  data_rs1_i,
    input  bus64_t  data_rs2_i,
    input  alu_op_t op_i,
    output bus64_t  result_o
);

logic do_sub;

// Only the two subtract forms flip the operation
assign do_sub = (op_i == SUB) || (op_i == SUBW);

always_comb begin
    if (do_sub) begin
        result_o = data_rs1_i - data_rs2_i;
    end else begin
        // rs1 already extended and pre-shifted
        result_o = data_rs1_i + data_rs2_i;
    end
end

endmodule

/* rtl/alu_pkg.sv */
package alu_pkg;

// --------------------------------------------------
// Data types
// --------------------------------------------------

typedef logic [63:0] bus64_t;
typedef logic [4:0]  reg_addr_t;

// Issue queue geometry
localparam int ALU_QUEUE_DEPTH = 4;
localparam int ALU_QUEUE_PTR_W = 2;

// --------------------------------------------------
// Integer operations
// --------------------------------------------------

typedef enum logic [4:0] {
    ADD,
    SUB,
    ADDW,
    SUBW,
    ADDUW,
    // Zba shift-and-add forms
    SH1ADD,
    SH2ADD,
    SH3ADD,
    SH1ADDUW,
    SH2ADDUW,
    SH3ADDUW,
    // Shifts
    SLL,
    SRL,
    SRA,
    SLLW,
    SRLW,
    SRAW,
    SLLIUW,
    // Compare
    SLT,
    SLTU,
    // Bitwise logic
    AND_INST,
    OR_INST,
    XOR_INST,
    ZEXTW
} alu_op_t;

// --------------------------------------------------
// Request and response words
// --------------------------------------------------

// Operand-ready instruction from the issue logic
typedef struct packed {
    alu_op_t   op;
    reg_addr_t rd;
    logic      regfile_we;
    bus64_t    data_rs1;
    bus64_t    data_rs2;
} alu_req_t;

// Result handed to writeback
typedef struct packed {
    reg_addr_t rd;
    logic      regfile_we;
    bus64_t    result;
} alu_resp_t;

endpackage
